/* hw/cam_bist_pkg.sv */
`default_nettype none

package cam_bist_pkg;

  // ========================================
  // Sequencer states
  // ========================================
  typedef enum logic [2:0] {
    IDLE,
    WRITE,
    READ,
    SEARCH_HIT,
    SEARCH_MISS,
    DRAIN,
    DONE
  } bist_state_t;

  // ========================================
  // Expected match vector select
  // ========================================
  // Decoded in the output handler, issued by the sequencer
  typedef enum logic [1:0] {
    ALL_MATCH       = 2'b00,
    SINGLE_MATCH    = 2'b01,
    SINGLE_MISMATCH = 2'b10,
    ALL_MISMATCH    = 2'b11
  } match_sel_t;

  // ========================================
  // APB register map, byte offsets
  // ========================================
  localparam logic [7:0] REG_CTRL      = 8'h00;
  localparam logic [7:0] REG_BG        = 8'h04;
  localparam logic [7:0] REG_MASK      = 8'h08;
  // Read only from here on
  localparam logic [7:0] REG_STATUS    = 8'h0C;
  localparam logic [7:0] REG_FAILCNT   = 8'h10;
  localparam logic [7:0] REG_FIRSTFAIL = 8'h14;

endpackage

`default_nettype wire

/* hw/cam_array.sv */
`timescale 1ns/1ns
`default_nettype none

module cam_array #(
  parameter int ENTRIES = 16,
  parameter int DWIDTH  = 8,
  parameter int AWIDTH  = 4
) (
  input  logic               bist_clk,
  input  logic               wr_en,
  input  logic [AWIDTH-1:0]  wr_addr,
  input  logic [DWIDTH-1:0]  wr_data,
  input  logic               rd_en,
  input  logic [AWIDTH-1:0]  rd_addr,
  input  logic               srch_en,
  input  logic [DWIDTH-1:0]  srch_key,
  input  logic [DWIDTH-1:0]  search_mask,
  output logic [DWIDTH-1:0]  rd_data,
  output logic [ENTRIES-1:0] match_lines
);

  // Storage cells
  logic [DWIDTH-1:0] mem [ENTRIES];

  // First stage: captured request
  logic              rd_en_q;
  logic [AWIDTH-1:0] rd_addr_q;
  logic              srch_en_q;
  logic [DWIDTH-1:0] srch_key_q;

  // ========================================
  // Write port
  // ========================================
  always_ff @(posedge bist_clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // ========================================
  // Request stage
  // ========================================
  always_ff @(posedge bist_clk) begin
    rd_en_q    <= rd_en;
    rd_addr_q  <= rd_addr;
    srch_en_q  <= srch_en;
    srch_key_q <= srch_key;
  end

  // ========================================
  // Output stage
  // ========================================
  // Read word, held until the next read
  always_ff @(posedge bist_clk) begin
    if (rd_en_q) begin
      rd_data <= mem[rd_addr_q];
    end
  end

  // Masked compare against every entry
  // A set mask bit drops that key bit from the compare
  always_ff @(posedge bist_clk) begin
    if (srch_en_q) begin
      for (int e = 0; e < ENTRIES; e++) begin
        match_lines[e] <= ((mem[e] ^ srch_key_q) & ~search_mask) == '0;
      end
    end
  end

endmodule

`default_nettype wire

/* hw/cam_bist_out_handler.sv */
`timescale 1ns/1ns
`default_nettype none

module cam_bist_out_handler #(
  parameter int ENTRIES = 16,
  parameter int DWIDTH  = 8,
  parameter int AWIDTH  = 4
) (
  input  logic                     bist_clk,
  input  logic                     cm_mode,
  input  cam_bist_pkg::match_sel_t match_sel,
  input  logic [AWIDTH-1:0]        bist_addr,
  input  logic [ENTRIES-1:0]       match_lines,
  input  logic [DWIDTH-1:0]        rd_data,
  output logic [DWIDTH-1:0]        check_data
);
  import cam_bist_pkg::*;

  logic [AWIDTH-1:0]  addr_q1;
  logic [AWIDTH-1:0]  addr_q2;
  logic [ENTRIES-1:0] onehot;
  logic [ENTRIES-1:0] expected;
  logic [ENTRIES-1:0] mismatch_vec;
  logic [DWIDTH-1:0]  compacted;

  // ========================================
  // Expected match vector
  // ========================================
  // Address follows the array's two-stage latency
  always_ff @(posedge bist_clk) begin
    addr_q1 <= bist_addr;
    addr_q2 <= addr_q1;
  end

  assign onehot = {{(ENTRIES-1){1'b0}}, 1'b1} << addr_q2;

  always_comb begin
    case (match_sel)
      ALL_MATCH:       expected = '1;
      SINGLE_MATCH:    expected = onehot;
      SINGLE_MISMATCH: expected = ~onehot;
      ALL_MISMATCH:    expected = '0;
      default:         expected = '0;
    endcase
  end

  // One bit per entry that disagrees
  assign mismatch_vec = expected ^ match_lines;

  // ========================================
  // Compactor
  // ========================================
  generate
    if (DWIDTH < ENTRIES) begin : g_fold
      // OR together entries that sit DWIDTH apart
      always_comb begin
        compacted = '0;
        for (int k = 0; k < ENTRIES; k++) begin
          compacted[k % DWIDTH] = compacted[k % DWIDTH] | mismatch_vec[k];
        end
      end
    end else if (DWIDTH == ENTRIES) begin : g_equal
      assign compacted = mismatch_vec;
    end else begin : g_pad
      // Upper bits never flag
      assign compacted = {{(DWIDTH-ENTRIES){1'b0}}, mismatch_vec};
    end
  endgenerate

  // Compare result replaces read data in CAM mode
  assign check_data = cm_mode ? compacted : rd_data;

  // Select code comes down the sequencer pipeline with the mode bit
  a_sel_known: assert property (@(posedge bist_clk) cm_mode |-> !$isunknown(match_sel));

endmodule

`default_nettype wire

/* hw/cam_bist_sequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module cam_bist_sequencer #(
  parameter int ENTRIES = 16,
  parameter int DWIDTH  = 8,
  parameter int AWIDTH  = 4
) (
  input  logic                      bist_clk,
  input  logic                      rst_n,
  input  logic                      start,
  input  logic [DWIDTH-AWIDTH-1:0]  bg_pattern,
  output logic                      busy,
  output logic                      done,
  output logic                      fail,
  output logic [AWIDTH+1:0]         fail_count,
  output logic [AWIDTH-1:0]         first_fail_addr,
  output logic                      wr_en,
  output logic [AWIDTH-1:0]         wr_addr,
  output logic [DWIDTH-1:0]         wr_data,
  output logic                      rd_en,
  output logic [AWIDTH-1:0]         rd_addr,
  output logic                      srch_en,
  output logic [DWIDTH-1:0]         srch_key,
  output logic                      cm_mode,
  output cam_bist_pkg::match_sel_t  match_sel,
  output logic [AWIDTH-1:0]         bist_addr,
  input  logic [DWIDTH-1:0]         check_data
);
  import cam_bist_pkg::*;

  localparam logic [AWIDTH-1:0] LAST_ADDR = AWIDTH'(ENTRIES - 1);
  localparam logic [DWIDTH-1:0] TOP_BIT   = {1'b1, {(DWIDTH-1){1'b0}}};

  bist_state_t       state;
  logic [AWIDTH-1:0] addr;
  logic [AWIDTH-1:0] addr_next;
  logic              addr_last;
  logic [DWIDTH-1:0] pattern;
  match_sel_t        issue_sel;

  // Expectation pipeline, two stages
  logic              v_q1;
  logic              v_q2;
  logic              mode_q1;
  logic              mode_q2;
  match_sel_t        sel_q1;
  match_sel_t        sel_q2;
  logic [DWIDTH-1:0] exp_q1;
  logic [DWIDTH-1:0] exp_q2;
  logic [AWIDTH-1:0] addr_q1;
  logic [AWIDTH-1:0] addr_q2;
  logic              chk_err;

  // ========================================
  // March FSM
  // ========================================
  assign addr_last = (addr == LAST_ADDR);
  assign addr_next = addr_last ? '0 : addr + 1'b1;

  always_ff @(posedge bist_clk) begin
    if (!rst_n) begin
      state <= IDLE;
      addr  <= '0;
    end else begin
      case (state)
        // Start only accepted when idle or finished
        IDLE, DONE: begin
          if (start) begin
            state <= WRITE;
            addr  <= '0;
          end
        end
        WRITE: begin
          addr <= addr_next;
          if (addr_last) state <= READ;
        end
        READ: begin
          addr <= addr_next;
          if (addr_last) state <= SEARCH_HIT;
        end
        SEARCH_HIT: begin
          addr <= addr_next;
          if (addr_last) state <= SEARCH_MISS;
        end
        SEARCH_MISS: begin
          addr <= addr_next;
          if (addr_last) state <= DRAIN;
        end
        // Two cycles for the last search to come back
        DRAIN: begin
          addr <= addr + 1'b1;
          if (addr == AWIDTH'(1)) begin
            state <= DONE;
            addr  <= '0;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign busy = (state != IDLE) && (state != DONE);
  assign done = (state == DONE);

  // ========================================
  // Array controls and patterns
  // ========================================
  // Background on top, entry index below
  assign pattern = {bg_pattern, addr};

  assign wr_en     = (state == WRITE);
  assign wr_addr   = addr;
  assign wr_data   = pattern;
  assign rd_en     = (state == READ);
  assign rd_addr   = addr;
  assign bist_addr = addr;
  assign srch_en   = (state == SEARCH_HIT) || (state == SEARCH_MISS);
  // Miss key flips the top background bit
  assign srch_key  = (state == SEARCH_MISS) ? (pattern ^ TOP_BIT) : pattern;
  assign issue_sel = (state == SEARCH_MISS) ? ALL_MISMATCH : SINGLE_MATCH;

  // ========================================
  // Expectation pipeline
  // ========================================
  always_ff @(posedge bist_clk) begin
    if (!rst_n) begin
      v_q1    <= 1'b0;
      v_q2    <= 1'b0;
      mode_q1 <= 1'b0;
      mode_q2 <= 1'b0;
      sel_q1  <= SINGLE_MATCH;
      sel_q2  <= SINGLE_MATCH;
    end else begin
      v_q1    <= rd_en || srch_en;
      v_q2    <= v_q1;
      mode_q1 <= srch_en;
      mode_q2 <= mode_q1;
      sel_q1  <= issue_sel;
      sel_q2  <= sel_q1;
    end
  end

  // Expected word and address travel alongside
  always_ff @(posedge bist_clk) begin
    exp_q1  <= pattern;
    exp_q2  <= exp_q1;
    addr_q1 <= addr;
    addr_q2 <= addr_q1;
  end

  // Out handler sees these in step with the array outputs
  assign cm_mode   = mode_q2;
  assign match_sel = sel_q2;

  // ========================================
  // Checker
  // ========================================
  // CAM mode wants no flagged bits, read mode wants the written word
  assign chk_err = v_q2 && (mode_q2 ? (check_data != '0) : (check_data != exp_q2));

  always_ff @(posedge bist_clk) begin
    if (!rst_n) begin
      fail            <= 1'b0;
      fail_count      <= '0;
      first_fail_addr <= '0;
    end else if (start && !busy) begin
      fail       <= 1'b0;
      fail_count <= '0;
    end else if (chk_err) begin
      fail <= 1'b1;
      // First failure of the run
      if (fail_count == '0) first_fail_addr <= addr_q2;
      // Saturate
      if (~&fail_count) fail_count <= fail_count + 1'b1;
    end
  end

  a_one_op: assert property (@(posedge bist_clk) disable iff (!rst_n)
    $onehot0({wr_en, rd_en, srch_en}));

endmodule

`default_nettype wire

/* hw/cam_bist_regs.sv */
`timescale 1ns/1ns
`default_nettype none

module cam_bist_regs #(
  parameter int ENTRIES = 16,
  parameter int DWIDTH  = 8,
  parameter int AWIDTH  = 4
) (
  input  logic                     bist_clk,
  input  logic                     rst_n,
  input  logic                     psel,
  input  logic                     penable,
  input  logic                     pwrite,
  input  logic [7:0]               paddr,
  input  logic [31:0]              pwdata,
  output logic [31:0]              prdata,
  output logic                     pready,
  output logic                     pslverr,
  output logic                     start,
  output logic [DWIDTH-AWIDTH-1:0] bg_pattern,
  output logic [DWIDTH-1:0]        search_mask,
  input  logic                     busy,
  input  logic                     done,
  input  logic                     fail,
  input  logic [AWIDTH+1:0]        fail_count,
  input  logic [AWIDTH-1:0]        first_fail_addr
);
  import cam_bist_pkg::*;

  logic        access;
  logic        wr_acc;
  logic        addr_hit;
  logic [31:0] rdata;

  // ========================================
  // APB decode
  // ========================================
  assign access = psel && penable;
  assign wr_acc = access && pwrite;
  // No wait states
  assign pready = 1'b1;

  always_comb begin
    addr_hit = 1'b1;
    rdata    = '0;
    case (paddr)
      // Start is write-only and reads zero
      REG_CTRL:      rdata = '0;
      REG_BG:        rdata[DWIDTH-AWIDTH-1:0] = bg_pattern;
      REG_MASK:      rdata[DWIDTH-1:0] = search_mask;
      REG_STATUS:    rdata[2:0] = {fail, done, busy};
      REG_FAILCNT:   rdata[AWIDTH+1:0] = fail_count;
      REG_FIRSTFAIL: rdata[AWIDTH-1:0] = first_fail_addr;
      default:       addr_hit = 1'b0;
    endcase
  end

  assign prdata  = (access && !pwrite) ? rdata : '0;
  assign pslverr = access && !addr_hit;

  // ========================================
  // Configuration and start
  // ========================================
  always_ff @(posedge bist_clk) begin
    if (!rst_n) begin
      start       <= 1'b0;
      bg_pattern  <= '0;
      search_mask <= '0;
    end else begin
      // One-cycle pulse per write of bit0
      start <= wr_acc && (paddr == REG_CTRL) && pwdata[0];
      // Setup frozen during a run
      if (wr_acc && !busy && (paddr == REG_BG)) begin
        bg_pattern <= pwdata[DWIDTH-AWIDTH-1:0];
      end
      if (wr_acc && !busy && (paddr == REG_MASK)) begin
        search_mask <= pwdata[DWIDTH-1:0];
      end
    end
  end

  // Error response only after a proper setup phase
  a_slverr_phase: assert property (@(posedge bist_clk) disable iff (!rst_n)
    pslverr |-> (psel && penable && $past(psel)));

endmodule

`default_nettype wire

/* hw/cam_bist_top.sv */
`timescale 1ns/1ns
`default_nettype none

module cam_bist_top #(
  parameter int ENTRIES = 16,
  parameter int DWIDTH  = 8,
  parameter int AWIDTH  = 4
) (
  input  logic        bist_clk,
  input  logic        rst_n,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [7:0]  paddr,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr,
  output logic        bist_busy,
  output logic        bist_done,
  output logic        bist_fail
);
  import cam_bist_pkg::*;

  // Regs to sequencer
  logic                     start;
  logic [DWIDTH-AWIDTH-1:0] bg_pattern;
  logic [DWIDTH-1:0]        search_mask;
  logic [AWIDTH+1:0]        fail_count;
  logic [AWIDTH-1:0]        first_fail_addr;

  // Sequencer to array
  logic                     wr_en;
  logic [AWIDTH-1:0]        wr_addr;
  logic [DWIDTH-1:0]        wr_data;
  logic                     rd_en;
  logic [AWIDTH-1:0]        rd_addr;
  logic                     srch_en;
  logic [DWIDTH-1:0]        srch_key;

  // Array and output handler path
  logic [DWIDTH-1:0]        rd_data;
  logic [ENTRIES-1:0]       match_lines;
  logic                     cm_mode;
  match_sel_t               match_sel;
  logic [AWIDTH-1:0]        bist_addr;
  logic [DWIDTH-1:0]        check_data;

  // ========================================
  // APB register block
  // ========================================
  cam_bist_regs #(
    .ENTRIES (ENTRIES),
    .DWIDTH  (DWIDTH),
    .AWIDTH  (AWIDTH)
  ) u_regs (
    .bist_clk        (bist_clk),
    .rst_n           (rst_n),
    .psel            (psel),
    .penable         (penable),
    .pwrite          (pwrite),
    .paddr           (paddr),
    .pwdata          (pwdata),
    .prdata          (prdata),
    .pready          (pready),
    .pslverr         (pslverr),
    .start           (start),
    .bg_pattern      (bg_pattern),
    .search_mask     (search_mask),
    .busy            (bist_busy),
    .done            (bist_done),
    .fail            (bist_fail),
    .fail_count      (fail_count),
    .first_fail_addr (first_fail_addr)
  );

  // ========================================
  // March sequencer
  // ========================================
  cam_bist_sequencer #(
    .ENTRIES (ENTRIES),
    .DWIDTH  (DWIDTH),
    .AWIDTH  (AWIDTH)
  ) u_seq (
    .bist_clk        (bist_clk),
    .rst_n           (rst_n),
    .start           (start),
    .bg_pattern      (bg_pattern),
    .busy            (bist_busy),
    .done            (bist_done),
    .fail            (bist_fail),
    .fail_count      (fail_count),
    .first_fail_addr (first_fail_addr),
    .wr_en           (wr_en),
    .wr_addr         (wr_addr),
    .wr_data         (wr_data),
    .rd_en           (rd_en),
    .rd_addr         (rd_addr),
    .srch_en         (srch_en),
    .srch_key        (srch_key),
    .cm_mode         (cm_mode),
    .match_sel       (match_sel),
    .bist_addr       (bist_addr),
    .check_data      (check_data)
  );

  // ========================================
  // CAM and compare path
  // ========================================
  cam_array #(
    .ENTRIES (ENTRIES),
    .DWIDTH  (DWIDTH),
    .AWIDTH  (AWIDTH)
  ) u_array (
    .bist_clk    (bist_clk),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .rd_en       (rd_en),
    .rd_addr     (rd_addr),
    .srch_en     (srch_en),
    .srch_key    (srch_key),
    .search_mask (search_mask),
    .rd_data     (rd_data),
    .match_lines (match_lines)
  );

  cam_bist_out_handler #(
    .ENTRIES (ENTRIES),
    .DWIDTH  (DWIDTH),
    .AWIDTH  (AWIDTH)
  ) u_out (
    .bist_clk    (bist_clk),
    .cm_mode     (cm_mode),
    .match_sel   (match_sel),
    .bist_addr   (bist_addr),
    .match_lines (match_lines),
    .rd_data     (rd_data),
    .check_data  (check_data)
  );

endmodule

`default_nettype wire

/* testbench/cam_bist_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module cam_bist_tb;
  import cam_bist_pkg::*;

  localparam int ENTRIES     = 16;
  localparam int DWIDTH      = 8;
  localparam int AWIDTH      = 4;
  localparam int BGWIDTH     = DWIDTH - AWIDTH;
  localparam int HALF_PERIOD = 50;
  // Four phases of ENTRIES operations, plus start and drain
  localparam int RUN_CYCLES  = 4 * ENTRIES + 3;
  localparam int CYCLE_LIMIT = 2000;
  localparam logic [7:0] REG_UNMAPPED = 8'h18;

  logic        bist_clk;
  logic        rst_n;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [7:0]  paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;
  logic        bist_busy;
  logic        bist_done;
  logic        bist_fail;

  integer             seed;
  logic [BGWIDTH-1:0] bg;
  logic [31:0]        rd_val;
  logic               rd_err;
  int cycle = 0;
  int start_cycle;
  int errors;
  int errors_seen;
  int tests_run;
  int tests_failed;

  cam_bist_top #(
    .ENTRIES (ENTRIES),
    .DWIDTH  (DWIDTH),
    .AWIDTH  (AWIDTH)
  ) uut (
    .bist_clk  (bist_clk),
    .rst_n     (rst_n),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .bist_busy (bist_busy),
    .bist_done (bist_done),
    .bist_fail (bist_fail)
  );

  // ========================================
  // Clock, cycle count and timeout
  // ========================================
  always #HALF_PERIOD bist_clk = ~bist_clk;

  always @(posedge bist_clk) begin
    cycle <= cycle + 1;
    if (cycle >= CYCLE_LIMIT) begin
      $display("timeout: the march tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // ========================================
  // Reporting helpers
  // ========================================
  task automatic report_failure(input string msg);
    errors++;
    $display("%s (at %0t ns)", msg, $time);
  endtask

  task automatic expect_value(input string what, input int got, input int exp);
    assert (got == exp) else begin
      errors++;
      $display("mismatch at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == errors_seen) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d failed checks", tests_run, name, errors - errors_seen);
    end
    errors_seen = errors;
  endtask

  // ========================================
  // APB master
  // ========================================
  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
    @(negedge bist_clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge bist_clk);
    penable = 1'b1;
    @(negedge bist_clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  // Data and error sampled mid access phase
  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
    @(negedge bist_clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge bist_clk);
    penable = 1'b1;
    #(HALF_PERIOD / 2);
    data = prdata;
    err  = pslverr;
    @(negedge bist_clk);
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic read_expect(input logic [7:0] addr, input int exp, input string what);
    logic [31:0] data;
    logic        err;
    apb_read(addr, data, err);
    expect_value(what, int'(data), exp);
    expect_value({what, " slave error"}, int'(err), 0);
  endtask

  // ========================================
  // March control
  // ========================================
  // Start cycle taken at the edge that saw the CTRL write
  task automatic start_march();
    apb_write(REG_CTRL, 32'h1);
    start_cycle = cycle;
    @(negedge bist_clk);
    assert (bist_busy) else report_failure("busy did not rise one cycle after start");
  endtask

  task automatic wait_done();
    do @(negedge bist_clk); while (!bist_done);
    expect_value("cycles from start to done", cycle - start_cycle, RUN_CYCLES);
    assert (!bist_busy) else report_failure("busy still high while done is high");
  endtask

  // ========================================
  // Reference model of the march
  // ========================================
  // Entry i holds background over index
  function automatic logic [DWIDTH-1:0] entry_word(input logic [BGWIDTH-1:0] pat, input int idx);
    return {pat, AWIDTH'(idx)};
  endfunction

  // Unmasked bits must all agree
  function automatic bit key_hits(input logic [DWIDTH-1:0] word, input logic [DWIDTH-1:0] key,
                                  input logic [DWIDTH-1:0] mask);
    for (int b = 0; b < DWIDTH; b++) begin
      if (!mask[b] && (word[b] != key[b])) return 1'b0;
    end
    return 1'b1;
  endfunction

  task automatic predict_failures(input logic [BGWIDTH-1:0] pat, input logic [DWIDTH-1:0] mask,
                                  output int count, output int first);
    logic [DWIDTH-1:0] key;
    logic              bad;
    count = 0;
    first = -1;
    // Hit phase, only the targeted entry may answer
    for (int i = 0; i < ENTRIES; i++) begin
      key = entry_word(pat, i);
      bad = !key_hits(entry_word(pat, i), key, mask);
      for (int j = 0; j < ENTRIES; j++) begin
        if (j != i && key_hits(entry_word(pat, j), key, mask)) bad = 1'b1;
      end
      if (bad) begin
        count++;
        if (first < 0) first = i;
      end
    end
    // Miss phase, top bit flipped so nothing should answer
    for (int i = 0; i < ENTRIES; i++) begin
      key = entry_word(pat, i);
      key[DWIDTH-1] = ~key[DWIDTH-1];
      bad = 1'b0;
      for (int j = 0; j < ENTRIES; j++) begin
        if (key_hits(entry_word(pat, j), key, mask)) bad = 1'b1;
      end
      if (bad) begin
        count++;
        if (first < 0) first = i;
      end
    end
  endtask

  task automatic check_run(input logic [BGWIDTH-1:0] pat, input logic [DWIDTH-1:0] mask);
    int count;
    int first;
    predict_failures(pat, mask, count, first);
    // Status is fail, done, busy
    read_expect(REG_STATUS, (count > 0) ? 6 : 2, "status after run");
    read_expect(REG_FAILCNT, count, "fail count");
    if (count > 0) read_expect(REG_FIRSTFAIL, first, "first fail address");
    expect_value("fail pin", int'(bist_fail), int'(count > 0));
  endtask

  // ========================================
  // Protocol checks
  // ========================================
  a_pready: assert property (@(posedge bist_clk) disable iff (!rst_n) pready)
    else report_failure("pready went low although the slave has no wait states");

  a_slverr: assert property (@(posedge bist_clk) disable iff (!rst_n)
    pslverr |-> (psel && penable))
    else report_failure("pslverr was raised outside an access phase");

  a_busy_done: assert property (@(posedge bist_clk) disable iff (!rst_n)
    !(bist_busy && bist_done))
    else report_failure("busy and done were high together");

  // Busy drops in the cycle that done rises
  a_done_edge: assert property (@(posedge bist_clk) disable iff (!rst_n)
    $rose(bist_done) |-> $fell(bist_busy))
    else report_failure("done rose without busy falling in the same cycle");

  // ========================================
  // Tests
  // ========================================
  initial begin
    seed         = 86;
    errors       = 0;
    errors_seen  = 0;
    tests_run    = 0;
    tests_failed = 0;
    bist_clk     = 1'b0;
    rst_n        = 1'b0;
    psel         = 1'b0;
    penable      = 1'b0;
    pwrite       = 1'b0;
    paddr        = '0;
    pwdata       = '0;
    repeat (4) @(negedge bist_clk);
    rst_n = 1'b1;

    assert (!bist_busy && !bist_done) else report_failure("busy or done high after reset");
    read_expect(REG_STATUS, 0, "status after reset");
    read_expect(REG_FAILCNT, 0, "fail count after reset");
    read_expect(REG_BG, 0, "background after reset");
    read_expect(REG_MASK, 0, "mask after reset");
    finish_test("reset state");

    bg = BGWIDTH'($random(seed));
    apb_write(REG_BG, 32'(bg));
    start_march();
    wait_done();
    check_run(bg, '0);
    finish_test("clean run");

    bg = BGWIDTH'($random(seed));
    apb_write(REG_BG, 32'(bg));
    read_expect(REG_BG, int'(bg), "background readback");
    apb_write(REG_MASK, 32'hA5);
    read_expect(REG_MASK, 'hA5, "mask readback");
    apb_read(REG_UNMAPPED, rd_val, rd_err);
    assert (rd_err) else report_failure("unmapped offset 0x18 did not raise pslverr");
    apb_write(REG_MASK, 32'h0);
    start_march();
    // Config is frozen during the march
    apb_write(REG_MASK, 32'hFF);
    read_expect(REG_MASK, 0, "mask written while busy");
    wait_done();
    check_run(bg, '0);
    finish_test("register behavior");

    // Bit0 masked, each hit key also matches its neighbour
    bg = BGWIDTH'($random(seed));
    apb_write(REG_BG, 32'(bg));
    apb_write(REG_MASK, 32'h1);
    start_march();
    wait_done();
    check_run(bg, DWIDTH'(1));
    finish_test("masked search");

    // Top bit masked, each miss key matches its entry
    apb_write(REG_MASK, 32'(1 << (DWIDTH - 1)));
    start_march();
    wait_done();
    check_run(bg, DWIDTH'(1 << (DWIDTH - 1)));
    finish_test("top bit mask");

    bg = BGWIDTH'($random(seed));
    apb_write(REG_BG, 32'(bg));
    apb_write(REG_MASK, 32'h0);
    start_march();
    repeat (5) @(negedge bist_clk);
    // Second start lands mid march and must not restart it
    apb_write(REG_CTRL, 32'h1);
    wait_done();
    check_run(bg, '0);
    finish_test("recovery");

    $display("summary: %0d tests run, %0d tests failed, %0d failed checks",
             tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
hw/cam_bist_pkg.sv
hw/cam_array.sv
hw/cam_bist_out_handler.sv
hw/cam_bist_sequencer.sv
hw/cam_bist_regs.sv
hw/cam_bist_top.sv
testbench/cam_bist_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cam_bist_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= *** PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
